// ==== Makefile ====
# Verilator build and run for the look-ahead route computer

TOP = lookahead_route_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		-Mdir $(OBJ) -o sim

run: compile
	./$(OBJ)/sim > sim.log 2>&1 || echo "Something failed" >> sim.log
	cat sim.log
	@if grep -q "Something failed" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ) sim.log

// ==== common/noc_geom_pkg.sv ====
package noc_geom_pkg;

    // mesh dimensions, routers per axis
    localparam int NX = 4;
    localparam int NY = 4;

    // coordinate widths, never below one bit even for a 1-wide mesh
    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    typedef logic [XW-1:0] coord_x_t;
    typedef logic [YW-1:0] coord_y_t;

    // highest address on each axis, used for edge wrap
    localparam coord_x_t LAST_X = coord_x_t'(NX - 1);
    localparam coord_y_t LAST_Y = coord_y_t'(NY - 1);

    // router address, x in the upper bits
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } router_addr_t;

endpackage

// ==== common/noc_port_pkg.sv ====
package noc_port_pkg;

    import noc_geom_pkg::*;

    // five ports of a mesh router
    localparam int PORT_NUM = 5;

    // port indices, north is toward smaller y
    typedef enum logic [2:0] {
        LOCAL = 3'd0,
        EAST  = 3'd1,
        NORTH = 3'd2,
        WEST  = 3'd3,
        SOUTH = 3'd4
    } port_dir_e;

    // one bit per port, indexed by port_dir_e
    typedef logic [PORT_NUM-1:0] port_onehot_t;

    // encoded destination port
    // {x_dir, y_dir} = 00 means the packet is for the local port
    typedef struct packed {
        logic east;     // 1 east, 0 west
        logic north;    // 1 north, 0 south
        logic x_dir;    // x hop wanted
        logic y_dir;    // y hop wanted
    } dst_port_t;

    // look-ahead port, only the hop request bits of each branch
    typedef struct packed {
        logic [1:0] x_ab;
        logic [1:0] y_ab;
    } lk_port_t;

    // header fields presented by the router each cycle
    typedef struct packed {
        logic         valid;
        router_addr_t dest;
        router_addr_t cur;
        dst_port_t    port;    // output port chosen at this router
    } route_req_t;

endpackage

// ==== dv/lookahead_route_props.sv ====
`timescale 1ns/1ps

module lookahead_route_props
    import noc_port_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input route_req_t req,
    input route_req_t req_q,
    input logic       lk_valid,
    input lk_port_t   lk_port
);

    // one register stage between request and result
    a_valid_delay: assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (lk_valid == $past(req.valid))
    ) else $error("lk_valid is not req.valid delayed by one cycle");

    a_valid_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !lk_valid
    ) else $error("lk_valid high in the first cycle after reset");

    // packet ends here, nothing to look ahead
    a_local_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_q.valid && !req_q.port.x_dir && !req_q.port.y_dir) |-> (lk_port == '0)
    ) else $error("local request gave a nonzero lk_port");

    a_west_no_y: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req_q.valid && req_q.port.x_dir && !req_q.port.east) |-> (lk_port.y_ab == 2'b00)
    ) else $error("westward request gave a nonzero y_ab");

endmodule

// ==== dv/lookahead_route_tb.sv ====
`timescale 1ns/1ps

module lookahead_route_tb
    import noc_geom_pkg::*;
    import noc_port_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED   = 32;    // 16 local + 16 corner pairs
    localparam int N_RANDOM     = 2000;
    localparam int N_TESTS      = N_DIRECTED + N_RANDOM;
    localparam int CLK_PERIOD   = 100;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_TESTS + 10) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    route_req_t req;
    logic       lk_valid;
    lk_port_t   lk_port;

    integer     seed;
    route_req_t prev_req;    // request whose result is due this cycle
    int         valid_errors;
    int         port_errors;
    int         other_errors;
    int         n_local;
    int         n_west;
    int         n_adaptive;
    int         n_single;

    lookahead_route_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .lk_valid (lk_valid),
        .lk_port  (lk_port)
    );

    bind lookahead_route_top lookahead_route_props props (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_q    (req_q),
        .lk_valid (lk_valid),
        .lk_port  (lk_port)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // west-first at position c toward d
    function automatic dst_port_t route_west_first(router_addr_t c, router_addr_t d);
        dst_port_t p;
        p = '0;
        if (d.x < c.x) begin
            p.x_dir = 1'b1;    // west alone
        end else begin
            p.x_dir = (d.x > c.x);
            p.east  = p.x_dir;
            p.y_dir = (d.y != c.y);
            p.north = (d.y < c.y);
        end
        return p;
    endfunction

    // one step on the mesh with wrap at the edges
    function automatic router_addr_t step_addr(router_addr_t a, port_dir_e dir);
        router_addr_t n;
        int x;
        int y;
        x = int'(a.x);
        y = int'(a.y);
        case (dir)
            EAST:    x = (x + 1) % NX;
            WEST:    x = (x + NX - 1) % NX;
            NORTH:   y = (y + NY - 1) % NY;    // north is smaller y
            SOUTH:   y = (y + 1) % NY;
            default: ;
        endcase
        n.x = coord_x_t'(x);
        n.y = coord_y_t'(y);
        return n;
    endfunction

    function automatic logic [1:0] branch_ab(router_addr_t nb, router_addr_t dest);
        dst_port_t p;
        p = route_west_first(nb, dest);
        return {p.x_dir, p.y_dir};
    endfunction

    // reference model for the look-ahead port
    function automatic lk_port_t expected_lk(route_req_t r);
        lk_port_t e;
        e = '0;    // local arrival leaves nothing to look ahead
        if (r.port.x_dir) begin
            e.x_ab = branch_ab(step_addr(r.cur, r.port.east ? EAST : WEST), r.dest);
        end
        if (r.port.y_dir) begin
            e.y_ab = branch_ab(step_addr(r.cur, r.port.north ? NORTH : SOUTH), r.dest);
        end
        return e;
    endfunction

    function automatic route_req_t make_request(router_addr_t cur, router_addr_t dest,
                                                logic valid);
        route_req_t r;
        r.valid = valid;
        r.dest  = dest;
        r.cur   = cur;
        r.port  = route_west_first(cur, dest);
        return r;
    endfunction

    function automatic router_addr_t random_addr();
        router_addr_t a;
        logic [31:0]  bits;
        bits = $random(seed);
        a.x  = bits[XW-1:0];    // NX and NY are powers of two
        a.y  = bits[XW+YW-1:XW];
        return a;
    endfunction

    function automatic router_addr_t corner_addr(int k);
        router_addr_t a;
        a.x = (k % 2 == 1) ? LAST_X : '0;
        a.y = (k / 2 == 1) ? LAST_Y : '0;
        return a;
    endfunction

    task automatic check_valid(input logic exp, input logic act);
        if (act !== exp) begin
            valid_errors++;
            $display("[ERROR] %0t lk_valid expected %b got %b", $time, exp, act);
        end
    endtask

    task automatic check_lk_port(input lk_port_t exp, input lk_port_t act);
        if (act !== exp) begin
            port_errors++;
            $display("[ERROR] %0t lk_port expected x_ab=%b y_ab=%b got x_ab=%b y_ab=%b",
                     $time, exp.x_ab, exp.y_ab, act.x_ab, act.y_ab);
        end
    endtask

    task automatic count_case(input dst_port_t p);
        if (!p.x_dir && !p.y_dir) begin
            n_local++;
        end else if (p.x_dir && !p.east) begin
            n_west++;
        end else if (p.x_dir && p.y_dir) begin
            n_adaptive++;
        end else begin
            n_single++;
        end
    endtask

    // check last cycle's result and present the next request
    task automatic run_cycle(input route_req_t r);
        @(negedge clk);
        check_valid(prev_req.valid, lk_valid);
        if (prev_req.valid) begin
            check_lk_port(expected_lk(prev_req), lk_port);
            count_case(prev_req.port);
        end
        req      = r;
        prev_req = r;
    endtask

    task automatic check_coverage();
        if (n_local == 0 || n_west == 0 || n_adaptive == 0 || n_single == 0) begin
            other_errors++;
            $display("not every kind of route was exercised");
            $display("route counts local %0d west %0d adaptive %0d single %0d",
                     n_local, n_west, n_adaptive, n_single);
        end
    endtask

    task automatic print_summary();
        $display("errors: lk_valid %0d, lk_port %0d, other %0d",
                 valid_errors, port_errors, other_errors);
    endtask

    initial begin
        router_addr_t cur;
        router_addr_t dest;
        logic [31:0]  bits;

        seed         = 36;
        req          = '0;
        prev_req     = '0;
        rst_n        = 1'b0;
        valid_errors = 0;
        port_errors  = 0;
        other_errors = 0;
        n_local      = 0;
        n_west       = 0;
        n_adaptive   = 0;
        n_single     = 0;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_valid(1'b0, lk_valid);
        end
        rst_n = 1'b1;

        // every router addressed to itself
        for (int a = 0; a < NX * NY; a++) begin
            cur.x = coord_x_t'(a % NX);
            cur.y = coord_y_t'(a / NX);
            run_cycle(make_request(cur, cur, 1'b1));
        end

        // corner to corner pairs cover the mesh edges
        for (int c = 0; c < 4; c++) begin
            for (int d = 0; d < 4; d++) begin
                run_cycle(make_request(corner_addr(c), corner_addr(d), 1'b1));
            end
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            cur  = random_addr();
            dest = random_addr();
            bits = $random(seed);
            if (i % 8 == 0) begin
                dest = cur;    // local arrival now and then
            end
            run_cycle(make_request(cur, dest, bits[2:0] != 3'd0));
        end
        run_cycle('0);    // drains the last result

        check_coverage();
        print_summary();
        if (valid_errors + port_errors + other_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("watchdog expired before all requests were checked");
        print_summary();
        $display("Something failed");
        $finish;
    end

endmodule

// ==== hop_branch/lookahead_hop.sv ====
`timescale 1ns/1ps

module lookahead_hop
    import noc_geom_pkg::*;
    import noc_port_pkg::*;
(
    input  port_onehot_t hop,
    input  router_addr_t cur,
    input  router_addr_t dest,
    output logic [1:0]   ab
);

    router_addr_t next_addr;
    dst_port_t    lk_dst;
    logic         hop_none;

    // where the packet lands after this hop
    next_router_addr predict (
        .hop  (hop),
        .cur  (cur),
        .next (next_addr)
    );

    // route again as the neighbour would
    west_first_route route (
        .cur  (next_addr),
        .dest (dest),
        .port (lk_dst)
    );

    // branch not taken at this router
    assign hop_none = (hop == '0);

    // only x_dir/y_dir are forwarded, an idle branch reports local
    assign ab = hop_none ? 2'b00 : {lk_dst.x_dir, lk_dst.y_dir};

endmodule

// ==== hop_branch/next_router_addr.sv ====
`timescale 1ns/1ps

module next_router_addr
    import noc_geom_pkg::*;
    import noc_port_pkg::*;
(
    input  port_onehot_t hop,
    input  router_addr_t cur,
    output router_addr_t next
);

    coord_x_t x_inc;
    coord_x_t x_dec;
    coord_y_t y_inc;
    coord_y_t y_dec;

    // one step along each axis, wrapping at the mesh edge
    // west-first never asks for a step off the mesh with legal inputs
    always_comb begin
        x_inc = (cur.x == LAST_X) ? '0 : cur.x + 1'b1;
        x_dec = (cur.x == '0) ? LAST_X : cur.x - 1'b1;
        y_inc = (cur.y == LAST_Y) ? '0 : cur.y + 1'b1;
        y_dec = (cur.y == '0) ? LAST_Y : cur.y - 1'b1;
    end

    // priority east, north, west, south
    always_comb begin
        next = cur;    // local or no hop keeps the address
        if (hop[EAST]) begin
            next.x = x_inc;
        end else if (hop[NORTH]) begin
            next.y = y_dec;    // north is toward smaller y
        end else if (hop[WEST]) begin
            next.x = x_dec;
        end else if (hop[SOUTH]) begin
            next.y = y_inc;
        end
    end

endmodule

// ==== hop_branch/west_first_route.sv ====
`timescale 1ns/1ps

module west_first_route
    import noc_geom_pkg::*;
    import noc_port_pkg::*;
(
    input  router_addr_t cur,
    input  router_addr_t dest,
    output dst_port_t    port
);

    logic go_west;
    logic go_east;
    logic go_north;
    logic go_south;

    // productive directions toward dest
    assign go_west  = (dest.x < cur.x);
    assign go_east  = (dest.x > cur.x);
    assign go_north = (dest.y < cur.y);
    assign go_south = (dest.y > cur.y);

    always_comb begin
        port = '0;    // same position means local

        if (go_west) begin
            // all west hops come first and alone
            port.x_dir = 1'b1;
            port.east  = 1'b0;
        end else begin
            // east and vertical offered together, router picks one
            port.x_dir = go_east;
            port.east  = go_east;
            port.y_dir = go_north | go_south;
            port.north = go_north;
        end
    end

endmodule

// ==== list.f ====
common/noc_geom_pkg.sv
common/noc_port_pkg.sv
hop_branch/west_first_route.sv
hop_branch/next_router_addr.sv
hop_branch/lookahead_hop.sv
verilog/destport_split.sv
verilog/lookahead_route_top.sv
dv/lookahead_route_props.sv
dv/lookahead_route_tb.sv

// ==== verilog/destport_split.sv ====
`timescale 1ns/1ps

module destport_split
    import noc_port_pkg::*;
(
    input  dst_port_t    port,
    output port_onehot_t x_hop,
    output port_onehot_t y_hop
);

    // each branch only sees the step along its own axis
    always_comb begin
        x_hop = '0;    // unused branch stays all zero
        y_hop = '0;

        if (!port.x_dir && !port.y_dir) begin
            // packet ends here, both branches stay put
            x_hop[LOCAL] = 1'b1;
            y_hop[LOCAL] = 1'b1;
        end else begin
            if (port.x_dir) begin
                if (port.east) begin
                    x_hop[EAST] = 1'b1;
                end else begin
                    x_hop[WEST] = 1'b1;
                end
            end

            if (port.y_dir) begin
                if (port.north) begin
                    y_hop[NORTH] = 1'b1;
                end else begin
                    y_hop[SOUTH] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/lookahead_route_top.sv ====
`timescale 1ns/1ps

module lookahead_route_top
    import noc_port_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  route_req_t req,
    output logic       lk_valid,
    output lk_port_t   lk_port
);

    route_req_t   req_q;
    port_onehot_t x_hop;
    port_onehot_t y_hop;
    logic [1:0]   x_ab;
    logic [1:0]   y_ab;

    // single register stage, new request every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else begin
            req_q <= req;
        end
    end

    // split the chosen port into one step per axis
    destport_split split (
        .port  (req_q.port),
        .x_hop (x_hop),
        .y_hop (y_hop)
    );

    // x branch, neighbour reached by the x hop
    lookahead_hop hop_x (
        .hop  (x_hop),
        .cur  (req_q.cur),
        .dest (req_q.dest),
        .ab   (x_ab)
    );

    // y branch, neighbour reached by the y hop
    lookahead_hop hop_y (
        .hop  (y_hop),
        .cur  (req_q.cur),
        .dest (req_q.dest),
        .ab   (y_ab)
    );

    // the next router rebuilds east/north itself, so only ab pairs travel
    assign lk_port.x_ab = x_ab;
    assign lk_port.y_ab = y_ab;

    assign lk_valid = req_q.valid;    // result is don't-care when low

endmodule
